// File: logic/itlb_pkg.sv
package itlb_pkg;

    localparam int VPN_W       = 20;
    localparam int PFN_W       = 20;
    localparam int OFFSET_W    = 12;
    localparam int ASID_W      = 4;
    localparam int TLB_ENTRIES = 16;
    localparam int IDX_W       = 4;

    // buffer refill machine
    localparam logic ST_IDLE   = 1'b0;
    localparam logic ST_SEARCH = 1'b1;

    // reset address lies in unmapped kseg0
    localparam logic [31:0] KSEG0_BASE = 32'h8000_0000;

    // one fetch address read by segment or by page
    typedef union packed {
        struct packed {
            logic [3:0]  seg;
            logic [27:0] rest;
        } seg_v;
        struct packed {
            logic [VPN_W-1:0]    vpn;
            logic [OFFSET_W-1:0] offset;
        } page;
    } vaddr_u;

endpackage

// File: logic/tlb_lookup_if.sv
`timescale 1ns/1ps

interface tlb_lookup_if
    import itlb_pkg::*;
();

    logic [VPN_W-1:0] vpn;
    logic             found;
    logic [IDX_W-1:0] index;
    logic [PFN_W-1:0] pfn;
    logic [2:0]       c;
    logic             d;
    logic             v;

    // buffer asks, array answers in the same cycle
    modport buffer (
        output vpn,
        input  found, index, pfn, c, d, v
    );

    modport array (
        input  vpn,
        output found, index, pfn, c, d, v
    );

endinterface

// File: logic/fetch_req_hold.sv
`timescale 1ns/1ps

module fetch_req_hold
    import itlb_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  logic   req,
    input  vaddr_u vaddr,
    input  logic   done,
    output logic   busy,
    output vaddr_u held_vaddr
);

    logic accept;

    // a new request may land on the edge that retires the old one
    assign accept = req && (!busy || done);

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
        end else if (accept) begin
            busy <= 1'b1;
        end else if (done) begin
            busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            held_vaddr <= KSEG0_BASE;
        end else if (accept) begin
            held_vaddr <= vaddr;   // stable until done
        end
    end

    // only one fetch in flight
    a_no_req_while_busy: assert property (@(posedge clk) disable iff (reset)
        req && busy |-> done)
        else $error("fetch request while busy");

endmodule

// File: logic/tlb_array.sv
`timescale 1ns/1ps

module tlb_array
    import itlb_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic [ASID_W-1:0] asid,
    input  logic              tlb_we,
    input  logic [IDX_W-1:0]  tlb_wr_index,
    input  logic [VPN_W-1:0]  tlb_wr_vpn,
    input  logic [ASID_W-1:0] tlb_wr_asid,
    input  logic              tlb_wr_g,
    input  logic [PFN_W-1:0]  tlb_wr_pfn,
    input  logic [2:0]        tlb_wr_c,
    input  logic              tlb_wr_d,
    input  logic              tlb_wr_v,
    tlb_lookup_if.array       lk
);

    logic [TLB_ENTRIES-1:0] ent_used;
    logic [VPN_W-1:0]       ent_vpn  [TLB_ENTRIES];
    logic [ASID_W-1:0]      ent_asid [TLB_ENTRIES];
    logic                   ent_g    [TLB_ENTRIES];
    logic [PFN_W-1:0]       ent_pfn  [TLB_ENTRIES];
    logic [2:0]             ent_c    [TLB_ENTRIES];
    logic                   ent_d    [TLB_ENTRIES];
    logic                   ent_v    [TLB_ENTRIES];
    logic [TLB_ENTRIES-1:0] match;

    always_ff @(posedge clk) begin
        if (reset) begin
            ent_used <= '0;
        end else if (tlb_we) begin
            ent_used[tlb_wr_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (tlb_we) begin
            ent_vpn[tlb_wr_index]  <= tlb_wr_vpn;
            ent_asid[tlb_wr_index] <= tlb_wr_asid;
            ent_g[tlb_wr_index]    <= tlb_wr_g;
            ent_pfn[tlb_wr_index]  <= tlb_wr_pfn;
            ent_c[tlb_wr_index]    <= tlb_wr_c;
            ent_d[tlb_wr_index]    <= tlb_wr_d;
            ent_v[tlb_wr_index]    <= tlb_wr_v;
        end
    end

    // global entries ignore asid
    always_comb begin
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            match[i] = ent_used[i] && (ent_vpn[i] == lk.vpn) &&
                       (ent_g[i] || (ent_asid[i] == asid));
        end
    end

    always_comb begin
        lk.found = 1'b0;
        lk.index = '0;
        lk.pfn   = '0;
        lk.c     = '0;
        lk.d     = 1'b0;
        lk.v     = 1'b0;
        for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin   // lowest index wins
            if (match[i]) begin
                lk.found = 1'b1;
                lk.index = IDX_W'(i);
                lk.pfn   = ent_pfn[i];
                lk.c     = ent_c[i];
                lk.d     = ent_d[i];
                lk.v     = ent_v[i];
            end
        end
    end

    a_single_match: assert property (@(posedge clk) disable iff (reset)
        $onehot0(match))
        else $error("tlb lookup matched more than one entry");

endmodule

// File: logic/itlb_stage.sv
`timescale 1ns/1ps

module itlb_stage
    import itlb_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  vaddr_u      held_vaddr,
    input  logic        flush,
    tlb_lookup_if.buffer lk,
    output logic        stall,
    output logic [31:0] paddr,
    output logic        refill,
    output logic        invalid
);

    logic             state_q;
    logic             state_n;
    logic             buf_wr;
    logic             buf_written;
    logic [VPN_W-1:0] buf_vpn;
    logic             buf_found;
    logic [PFN_W-1:0] buf_pfn;
    logic             buf_v;
    logic             unmapped;
    logic             kseg1;
    logic             hit;

    assign unmapped = (held_vaddr.seg_v.seg[3:2] == 2'b10);   // 8..B
    assign kseg1    = (held_vaddr.seg_v.seg[3:1] == 3'b101);  // A, B

    assign hit   = unmapped || (buf_written && (buf_vpn == held_vaddr.page.vpn));
    assign stall = !hit;

    assign lk.vpn = held_vaddr.page.vpn;

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_n;
        end
    end

    always_comb begin
        case (state_q)
            ST_IDLE:   state_n = stall ? ST_SEARCH : ST_IDLE;
            ST_SEARCH: state_n = ST_IDLE;   // buffer loaded so retry
            default:   state_n = ST_IDLE;
        endcase
    end

    assign buf_wr = (state_q == ST_SEARCH);

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            buf_written <= 1'b0;
        end else if (buf_wr) begin
            buf_written <= 1'b1;
        end
    end

    // tag kept on a tlb miss too, so the miss turns into a refill
    always_ff @(posedge clk) begin
        if (buf_wr) begin
            buf_vpn   <= lk.vpn;
            buf_found <= lk.found;
            buf_pfn   <= lk.pfn;
            buf_v     <= lk.v;
        end
    end

    always_comb begin
        if (kseg1) begin
            paddr = {3'b000, held_vaddr.seg_v.seg[0], held_vaddr.seg_v.rest};
        end else if (unmapped) begin
            paddr = {1'b0, held_vaddr.seg_v.seg[2:0], held_vaddr.seg_v.rest};
        end else begin
            paddr = {buf_pfn, held_vaddr.page.offset};
        end
    end

    assign refill  = !unmapped && !buf_found;
    assign invalid = !unmapped && buf_found && !buf_v;

endmodule

// File: logic/fetch_resp.sv
`timescale 1ns/1ps

module fetch_resp (
    input  logic        clk,
    input  logic        reset,
    input  logic        busy,
    input  logic        stall,
    input  logic [31:0] paddr,
    input  logic        refill,
    input  logic        invalid,
    output logic        done,
    output logic        resp_valid,
    output logic [31:0] resp_paddr,
    output logic        resp_refill,
    output logic        resp_invalid
);

    assign done = busy && !stall;   // first unstalled cycle

    always_ff @(posedge clk) begin
        if (reset) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= done;
        end
    end

    always_ff @(posedge clk) begin
        if (done) begin
            resp_paddr   <= paddr;
            resp_refill  <= refill;
            resp_invalid <= invalid;
        end
    end

    a_one_exception: assert property (@(posedge clk) disable iff (reset)
        resp_valid |-> !(resp_refill && resp_invalid))
        else $error("refill and invalid raised together");

endmodule

// File: logic/itlb_top.sv
`timescale 1ns/1ps

module itlb_top
    import itlb_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              req,
    input  logic [31:0]       vaddr,
    output logic              busy,
    input  logic [ASID_W-1:0] asid,
    input  logic              tlb_we,
    input  logic [IDX_W-1:0]  tlb_wr_index,
    input  logic [VPN_W-1:0]  tlb_wr_vpn,
    input  logic [ASID_W-1:0] tlb_wr_asid,
    input  logic              tlb_wr_g,
    input  logic [PFN_W-1:0]  tlb_wr_pfn,
    input  logic [2:0]        tlb_wr_c,
    input  logic              tlb_wr_d,
    input  logic              tlb_wr_v,
    input  logic              buffer_flush,
    output logic              resp_valid,
    output logic [31:0]       resp_paddr,
    output logic              resp_refill,
    output logic              resp_invalid
);

    vaddr_u      held_vaddr;
    logic        done;
    logic        stall;
    logic [31:0] paddr;
    logic        refill;
    logic        invalid;

    tlb_lookup_if lk_if ();

    fetch_req_hold req_hold_i (
        .clk        (clk),
        .reset      (reset),
        .req        (req),
        .vaddr      (vaddr),
        .done       (done),
        .busy       (busy),
        .held_vaddr (held_vaddr)
    );

    itlb_stage stage_i (
        .clk        (clk),
        .reset      (reset),
        .held_vaddr (held_vaddr),
        .flush      (buffer_flush),
        .lk         (lk_if.buffer),
        .stall      (stall),
        .paddr      (paddr),
        .refill     (refill),
        .invalid    (invalid)
    );

    tlb_array tlb_i (
        .clk          (clk),
        .reset        (reset),
        .asid         (asid),
        .tlb_we       (tlb_we),
        .tlb_wr_index (tlb_wr_index),
        .tlb_wr_vpn   (tlb_wr_vpn),
        .tlb_wr_asid  (tlb_wr_asid),
        .tlb_wr_g     (tlb_wr_g),
        .tlb_wr_pfn   (tlb_wr_pfn),
        .tlb_wr_c     (tlb_wr_c),
        .tlb_wr_d     (tlb_wr_d),
        .tlb_wr_v     (tlb_wr_v),
        .lk           (lk_if.array)
    );

    fetch_resp resp_i (
        .clk          (clk),
        .reset        (reset),
        .busy         (busy),
        .stall        (stall),
        .paddr        (paddr),
        .refill       (refill),
        .invalid      (invalid),
        .done         (done),
        .resp_valid   (resp_valid),
        .resp_paddr   (resp_paddr),
        .resp_refill  (resp_refill),
        .resp_invalid (resp_invalid)
    );

endmodule

// File: bench/itlb_tb.sv
`timescale 1ns/1ps

module itlb_tb
    import itlb_pkg::*;
();

    logic              clk;
    logic              reset;
    logic              req;
    logic [31:0]       vaddr;
    logic              busy;
    logic [ASID_W-1:0] asid;
    logic              tlb_we;
    logic [IDX_W-1:0]  tlb_wr_index;
    logic [VPN_W-1:0]  tlb_wr_vpn;
    logic [ASID_W-1:0] tlb_wr_asid;
    logic              tlb_wr_g;
    logic [PFN_W-1:0]  tlb_wr_pfn;
    logic [2:0]        tlb_wr_c;
    logic              tlb_wr_d;
    logic              tlb_wr_v;
    logic              buffer_flush;
    logic              resp_valid;
    logic [31:0]       resp_paddr;
    logic              resp_refill;
    logic              resp_invalid;

    string cases[$];
    int    case_count = 0;
    int    mismatches = 0;
    int    other_errs = 0;

    always #5 clk = ~clk;

    itlb_top dut_i (.*);

    task automatic check_paddr(input string name, input logic [31:0] exp_val,
                               input logic [31:0] act_val);
        if (act_val !== exp_val) begin
            $display("ERROR %s paddr expected %h actual %h", name, exp_val, act_val);
            mismatches++;
        end
    endtask

    // {refill, invalid}
    task automatic check_flags(input string name, input logic [1:0] exp_val,
                               input logic [1:0] act_val);
        if (act_val !== exp_val) begin
            $display("ERROR %s flags expected %b actual %b", name, exp_val, act_val);
            mismatches++;
        end
    endtask

    task automatic check_busy(input string name, input logic exp_val,
                              input logic act_val);
        if (act_val !== exp_val) begin
            $display("ERROR %s busy expected %b actual %b", name, exp_val, act_val);
            mismatches++;
        end
    endtask

    task automatic write_tlb_entry(input string line);
        logic [IDX_W-1:0]  idx;
        logic [VPN_W-1:0]  vpn;
        logic [ASID_W-1:0] wasid;
        logic              g;
        logic [PFN_W-1:0]  pfn;
        logic [2:0]        c;
        logic              d;
        logic              v;
        int                n;
        n = $sscanf(line, "W %h %h %h %h %h %h %h %h", idx, vpn, wasid, g, pfn, c, d, v);
        if (n != 8) begin
            $display("malformed write line in case file: %s", line);
            other_errs++;
        end else begin
            @(posedge clk);
            tlb_we       <= 1'b1;
            tlb_wr_index <= idx;
            tlb_wr_vpn   <= vpn;
            tlb_wr_asid  <= wasid;
            tlb_wr_g     <= g;
            tlb_wr_pfn   <= pfn;
            tlb_wr_c     <= c;
            tlb_wr_d     <= d;
            tlb_wr_v     <= v;
            @(posedge clk);
            tlb_we <= 1'b0;
        end
    endtask

    task automatic flush_buffer();
        @(posedge clk);
        buffer_flush <= 1'b1;
        @(posedge clk);
        buffer_flush <= 1'b0;
    endtask

    task automatic run_request(input string line);
        string             name;
        logic [31:0]       va;
        logic [ASID_W-1:0] a;
        logic [31:0]       exp_pa;
        logic              exp_rf;
        logic              exp_inv;
        int                n;
        int                waited;
        n = $sscanf(line, "R %s %h %h %h %h %h", name, va, a, exp_pa, exp_rf, exp_inv);
        if (n != 6) begin
            $display("malformed request line in case file: %s", line);
            other_errs++;
        end else begin
            @(posedge clk);
            vaddr <= va;
            asid  <= a;
            req   <= 1'b1;
            @(posedge clk);
            req <= 1'b0;
            waited = 0;
            @(negedge clk);
            check_busy(name, 1'b1, busy);   // held from acceptance
            while (!resp_valid && waited < 20) begin
                @(negedge clk);
                waited++;
            end
            if (!resp_valid) begin
                $display("request %s got no response within 20 cycles", name);
                other_errs++;
            end else begin
                check_busy(name, 1'b0, busy);   // freed with the response
                check_flags(name, {exp_rf, exp_inv}, {resp_refill, resp_invalid});
                if (!exp_rf && !exp_inv) check_paddr(name, exp_pa, resp_paddr);  // clean only
            end
        end
    endtask

    // 20 cycles allowed per case line
    initial begin
        wait (case_count > 0);
        repeat (case_count * 20 + 20) @(posedge clk);
        $display("watchdog expired after %0d cycles, run stopped", case_count * 20 + 20);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        int    fd;
        string line;
        clk          = 1'b0;
        reset        = 1'b1;
        req          = 1'b0;
        vaddr        = '0;
        asid         = '0;
        tlb_we       = 1'b0;
        tlb_wr_index = '0;
        tlb_wr_vpn   = '0;
        tlb_wr_asid  = '0;
        tlb_wr_g     = 1'b0;
        tlb_wr_pfn   = '0;
        tlb_wr_c     = '0;
        tlb_wr_d     = 1'b0;
        tlb_wr_v     = 1'b0;
        buffer_flush = 1'b0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;

        fd = $fopen("bench/itlb_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open bench/itlb_cases.txt");
            other_errs++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                if ($fgets(line, fd) > 0 && line.len() > 1 && line[0] != "#")
                    cases.push_back(line);
            end
            $fclose(fd);
            if (cases.size() == 0) begin
                $display("case file holds no cases");
                other_errs++;
            end
        end
        case_count = cases.size();

        foreach (cases[i]) begin
            case (cases[i][0])
                "W":     write_tlb_entry(cases[i]);
                "F":     flush_buffer();
                "R":     run_request(cases[i]);
                default: begin
                    $display("unknown line kind in case file: %s", cases[i]);
                    other_errs++;
                end
            endcase
        end

        @(posedge clk);
        $display("summary: %0d value errors, %0d other errors", mismatches, other_errs);
        if (mismatches + other_errs == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

// File: bench/itlb_cases.txt
# W index vpn asid g pfn c d v | F (flush) | R name vaddr asid paddr refill invalid, all hex
# paddr is compared only when neither flag is expected
R kseg0_low 80001234 0 00001234 0 0
R kseg0_high 9fc00380 0 1fc00380 0 0
R kseg1_low a0000100 0 00000100 0 0
R kseg1_high bfc00000 0 1fc00000 0 0
R refill_empty 00400010 1 00000000 1 0
W 0 00400 1 0 12345 3 1 1
F
R mapped_hit 00400abc 1 12345abc 0 0
R mapped_again 00400ff0 1 12345ff0 0 0
F
R refill_asid 00400004 2 00000000 1 0
W 1 00800 2 0 0abcd 2 0 0
R invalid_page 00800100 2 00000000 0 1
R refill_nomatch 00c00000 2 00000000 1 0
W 0 00400 1 0 54321 3 1 1
F
R rewrite_new 00400123 1 54321123 0 0
W 2 01000 5 1 0f0f0 3 0 1
R global_a 01000444 7 0f0f0444 0 0
F
R global_b 01000888 3 0f0f0888 0 0
R kseg1_after a0400010 3 00400010 0 0

// File: build.f
logic/itlb_pkg.sv
logic/tlb_lookup_if.sv
logic/fetch_req_hold.sv
logic/tlb_array.sv
logic/itlb_stage.sv
logic/fetch_resp.sv
logic/itlb_top.sv
bench/itlb_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile with Verilator and run the ITLB testbench from the project root
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -j 0 --top-module itlb_tb -f build.f \
        -Mdir obj_dir -o itlb_sim; then
    echo "compile failed"
    exit 1
fi

./obj_dir/itlb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Done: errors found" sim.log; then
    exit 1
fi
exit 0
